//--- src.f
source/lcd_pkg.sv
source/lcd_panel_ctrl.sv
source/write_queue.sv
source/lcd_bus_merge.sv
source/lcd_multi_top.sv
test/tb_lcd_multi.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_lcd_multi
FILELIST  = src.f
OBJ_DIR   = obj_dir

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_lcd_multi.sv
`timescale 1ns/10ps

module tb_lcd_multi import lcd_pkg::*; ();

	localparam int NUM_WRITES = 12;
	localparam int MAX_EXP = NUM_WRITES + 4;    // init bytes plus writes
	localparam int SETUP_US = T_POWERUP_US + 4 * T_E_HIGH_US + 2 * T_INIT_STEP_US
		+ T_CLEAR_US + T_ENTRY_US;
	localparam int CYCLE_LIMIT = 2 * (SETUP_US + NUM_WRITES * (T_WRITE_US + 1)) * CLK_PER_US;
	localparam lcd_cfg_t CFG = 7'b1101110;

	logic clk;
	logic rst_n;
	lcd_cfg_t cfg;
	logic host_valid;
	panel_idx_t host_panel;
	lcd_word_t host_word;
	logic queue_full;
	logic [NUM_PANELS-1:0] lcd_e;
	lcd_byte_t lcd_data;
	logic lcd_rs;
	logic lcd_rw;
	logic ready;

	panel_idx_t tab_panel [NUM_WRITES];
	logic tab_rs [NUM_WRITES];
	logic tab_rw [NUM_WRITES];
	lcd_byte_t tab_data [NUM_WRITES];
	lcd_word_t exp_word [NUM_PANELS][MAX_EXP];  // per-panel expected edges, in order
	int exp_cnt [NUM_PANELS];
	int seen_cnt [NUM_PANELS];
	logic [NUM_PANELS-1:0] e_prev;
	int run_cyc = 0;                            // cycles since reset release
	int cyc = 0;
	logic full_seen;
	integer seed;

	lcd_multi_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.host_valid (host_valid),
		.host_panel (host_panel),
		.host_word  (host_word),
		.queue_full (queue_full),
		.lcd_e      (lcd_e),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.ready      (ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_word(input string name, input lcd_word_t got, input lcd_word_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	// HD44780 init commands from the configuration bits
	function automatic lcd_byte_t init_cmd(input lcd_cfg_t c, input int step);
		case (step)
			0: return {4'b0011, c[6], c[5], 2'b00};         // function set
			1: return {5'b00001, c[4], c[3], c[2]};         // display on/off
			2: return 8'h01;                                // clear
			default: return {6'b000001, c[1], c[0]};        // entry mode
		endcase
	endfunction

	function automatic lcd_byte_t next_rand();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic logic all_seen();
		for (int p = 0; p < NUM_PANELS; p++)
			if (seen_cnt[p] != exp_cnt[p])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic set_entry(input int i, input panel_idx_t p, input logic rs, input logic rw,
			input lcd_byte_t d);
		tab_panel[i] = p;
		tab_rs[i] = rs;
		tab_rw[i] = rw;
		tab_data[i] = d;
	endtask

	task automatic load_table();
		set_entry(0, 1'b0, 1'b1, 1'b0, 8'h48);
		set_entry(1, 1'b1, 1'b1, 1'b0, 8'h65);
		set_entry(2, 1'b0, 1'b1, 1'b0, next_rand());
		set_entry(3, 1'b1, 1'b0, 1'b0, 8'hc0);      // ddram address, line 2
		set_entry(4, 1'b1, 1'b1, 1'b0, next_rand());
		set_entry(5, 1'b0, 1'b0, 1'b1, 8'h00);      // rw only passed to the pin
		set_entry(6, 1'b0, 1'b1, 1'b0, next_rand());
		set_entry(7, 1'b1, 1'b1, 1'b0, next_rand());
		set_entry(8, 1'b0, 1'b0, 1'b0, 8'h02);      // return home
		set_entry(9, 1'b1, 1'b1, 1'b1, next_rand());
		set_entry(10, 1'b1, 1'b1, 1'b0, 8'h7e);
		set_entry(11, 1'b0, 1'b1, 1'b0, next_rand());
	endtask

	task automatic add_expected(input panel_idx_t p, input lcd_word_t w);
		if (exp_cnt[p] >= MAX_EXP)
			fail_run("expected queue overflow in testbench");
		exp_word[p][exp_cnt[p]] = w;
		exp_cnt[p]++;
	endtask

	task automatic check_edge(input int p);
		lcd_word_t exp;
		if (seen_cnt[p] >= exp_cnt[p])
			fail_run($sformatf("unexpected enable edge on panel %0d at %0t", p, $time));
		exp = exp_word[p][seen_cnt[p]];
		check_byte($sformatf("lcd_data (panel %0d)", p), lcd_data, exp[7:0]);
		check_word($sformatf("lcd word (panel %0d)", p), {lcd_rs, lcd_rw, lcd_data}, exp);
		seen_cnt[p]++;
	endtask

	// counts the same edges the DUT counts
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			run_cyc <= 0;
		else
			run_cyc <= run_cyc + 1;
	end

	// bus monitor, pins sampled mid-cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			e_prev = '0;
		end else begin
			if (queue_full)
				full_seen = 1'b1;
			for (int p = 0; p < NUM_PANELS; p++) begin
				if (!e_prev[p] && lcd_e[p] && run_cyc < T_POWERUP_US * CLK_PER_US)
					fail_run($sformatf("enable on panel %0d rose during power-up", p));
				if (e_prev[p] && !lcd_e[p])
					check_edge(p);                  // falling edge latches the bus
			end
			e_prev = lcd_e;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT)
			fail_run($sformatf("timeout after %0d cycles, writes still pending", cyc));
	end

	initial begin
		lcd_word_t w;
		rst_n = 1'b0;
		cfg = CFG;
		host_valid = 1'b0;
		host_panel = '0;
		host_word = '0;
		seed = 32'h47f9;
		full_seen = 1'b0;
		for (int p = 0; p < NUM_PANELS; p++) begin
			exp_cnt[p] = 0;
			seen_cnt[p] = 0;
		end
		load_table();
		for (int s = 0; s < 4; s++)
			for (int p = 0; p < NUM_PANELS; p++)
				add_expected(p, {2'b00, init_cmd(CFG, s)});   // lockstep init on all panels
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int p = 0; p < NUM_PANELS; p++)
			check_bit($sformatf("lcd_e[%0d]", p), lcd_e[p], 1'b0);
		check_bit("lcd_rs", lcd_rs, 1'b0);
		check_bit("lcd_rw", lcd_rw, 1'b0);
		check_byte("lcd_data", lcd_data, 8'h00);
		check_bit("ready", ready, 1'b0);

		// first eight land during init and fill the queue
		for (int i = 0; i < NUM_WRITES; i++) begin
			@(negedge clk);
			host_valid = 1'b0;
			while (queue_full)
				@(negedge clk);
			w = {tab_rs[i], tab_rw[i], tab_data[i]};
			host_valid = 1'b1;
			host_panel = tab_panel[i];
			host_word = w;
			add_expected(tab_panel[i], w);
		end
		@(negedge clk);
		host_valid = 1'b0;

		while (!(all_seen() && ready))
			@(negedge clk);
		repeat (T_WRITE_US * CLK_PER_US) @(negedge clk);     // quiet period for stray edges
		check_bit("queue_full seen", full_seen, 1'b1);
		check_bit("ready", ready, 1'b1);
		for (int p = 0; p < NUM_PANELS; p++)
			if (seen_cnt[p] != exp_cnt[p])
				fail_run($sformatf("panel %0d saw %0d enable edges, %0d expected", p,
					seen_cnt[p], exp_cnt[p]));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- source/lcd_multi_top.sv
`timescale 1ns/10ps

module lcd_multi_top import lcd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lcd_cfg_t              cfg,
	input  logic                  host_valid,
	input  panel_idx_t            host_panel,
	input  lcd_word_t             host_word,
	output logic                  queue_full,
	output logic [NUM_PANELS-1:0] lcd_e,
	output lcd_byte_t             lcd_data,
	output logic                  lcd_rs,
	output logic                  lcd_rw,
	output logic                  ready
);

	logic [NUM_PANELS-1:0] panel_start;
	logic [NUM_PANELS-1:0] panel_busy;
	logic [NUM_PANELS-1:0] panel_e;
	logic [NUM_PANELS-1:0] panel_active;
	logic [NUM_PANELS-1:0] panel_rs;
	logic [NUM_PANELS-1:0] panel_rw;
	lcd_byte_t [NUM_PANELS-1:0] panel_data;
	lcd_word_t queue_word;
	logic queue_empty;

	write_queue queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.host_valid  (host_valid),
		.host_panel  (host_panel),
		.host_word   (host_word),
		.panel_busy  (panel_busy),
		.queue_full  (queue_full),
		.queue_empty (queue_empty),
		.panel_start (panel_start),
		.out_word    (queue_word)
	);

	for (genvar p = 0; p < NUM_PANELS; p++) begin : g_panel
		lcd_panel_ctrl panel_i (
			.clk    (clk),
			.rst_n  (rst_n),
			.cfg    (cfg),              // same cfg, so init runs in lockstep
			.start  (panel_start[p]),
			.word   (queue_word),
			.e      (panel_e[p]),
			.data   (panel_data[p]),
			.rs     (panel_rs[p]),
			.rw     (panel_rw[p]),
			.busy   (panel_busy[p]),
			.active (panel_active[p])
		);
	end

	lcd_bus_merge merge_i (
		.panel_e      (panel_e),
		.panel_active (panel_active),
		.panel_rs     (panel_rs),
		.panel_rw     (panel_rw),
		.panel_data   (panel_data),
		.lcd_e        (lcd_e),
		.lcd_data     (lcd_data),
		.lcd_rs       (lcd_rs),
		.lcd_rw       (lcd_rw)
	);

	// a start in flight counts as pending work
	assign ready = queue_empty && (panel_busy == '0) && (panel_start == '0);

endmodule

//--- source/lcd_bus_merge.sv
`timescale 1ns/10ps

module lcd_bus_merge import lcd_pkg::*; (
	input  logic      [NUM_PANELS-1:0] panel_e,
	input  logic      [NUM_PANELS-1:0] panel_active,
	input  logic      [NUM_PANELS-1:0] panel_rs,
	input  logic      [NUM_PANELS-1:0] panel_rw,
	input  lcd_byte_t [NUM_PANELS-1:0] panel_data,
	output logic      [NUM_PANELS-1:0] lcd_e,
	output lcd_byte_t                  lcd_data,
	output logic                       lcd_rs,
	output logic                       lcd_rw
);

	// lowest active index wins, walking down so it is assigned last
	always_comb begin
		lcd_data = '0;
		lcd_rs = 1'b0;
		lcd_rw = 1'b0;
		for (int i = NUM_PANELS - 1; i >= 0; i--) begin
			if (panel_active[i]) begin
				lcd_data = panel_data[i];
				lcd_rs = panel_rs[i];
				lcd_rw = panel_rw[i];
			end
		end
	end

	assign lcd_e = panel_e;                     // one strobe pin per chip

endmodule

//--- source/write_queue.sv
`timescale 1ns/10ps

module write_queue import lcd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  host_valid,
	input  panel_idx_t            host_panel,
	input  lcd_word_t             host_word,
	input  logic [NUM_PANELS-1:0] panel_busy,
	output logic                  queue_full,
	output logic                  queue_empty,
	output logic [NUM_PANELS-1:0] panel_start,
	output lcd_word_t             out_word
);

	panel_idx_t tag_mem [QUEUE_DEPTH];
	lcd_word_t word_mem [QUEUE_DEPTH];
	logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(QUEUE_DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	assign queue_full = (count == QUEUE_DEPTH);
	assign queue_empty = (count == '0);
	assign push = host_valid && !queue_full;    // strobes while full are lost

	// shared bus: release only when nothing is busy and no start is in flight
	assign pop = !queue_empty && (panel_busy == '0) && (panel_start == '0);

	always_ff @(posedge clk) begin
		if (push) begin
			tag_mem[wr_ptr] <= host_panel;
			word_mem[wr_ptr] <= host_word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one-cycle start to the tagged panel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			panel_start <= '0;
		end else begin
			panel_start <= '0;
			if (pop)
				panel_start[tag_mem[rd_ptr]] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			out_word <= word_mem[rd_ptr];       // valid alongside panel_start
	end

endmodule

//--- source/lcd_panel_ctrl.sv
`timescale 1ns/10ps

module lcd_panel_ctrl import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_cfg_t  cfg,
	input  logic      start,
	input  lcd_word_t word,
	output logic      e,
	output lcd_byte_t data,
	output logic      rs,
	output logic      rw,
	output logic      busy,
	output logic      active
);

	panel_state_t state;
	logic [$clog2(CLK_PER_US)-1:0] pre_cnt;     // cycles within one microsecond
	logic [$clog2(T_POWERUP_US)-1:0] us_cnt;    // microseconds into current phase
	logic [1:0] step;                           // init command index
	lcd_word_t word_q;
	logic us_tick;
	logic phase_done;
	int unsigned phase_len;
	lcd_byte_t init_byte;

	assign us_tick = (pre_cnt == CLK_PER_US - 1);
	assign phase_done = us_tick && (us_cnt == phase_len - 1);

	// length of the running phase in microseconds
	always_comb begin
		phase_len = 1;
		case (state)
			powerup: phase_len = T_POWERUP_US;
			init: begin
				case (step)
					2'd0: phase_len = T_E_HIGH_US + T_INIT_STEP_US;
					2'd1: phase_len = T_E_HIGH_US + T_INIT_STEP_US;
					2'd2: phase_len = T_E_HIGH_US + T_CLEAR_US;
					default: phase_len = T_E_HIGH_US + T_ENTRY_US;
				endcase
			end
			write: phase_len = T_WRITE_US;
			default: phase_len = 1;             // idle does not count
		endcase
	end

	// the four init commands built from cfg
	always_comb begin
		case (step)
			2'd0: init_byte = {4'b0011, cfg[CFG_LINES], cfg[CFG_FONT], 2'b00};
			2'd1: init_byte = {5'b00001, cfg[CFG_DISPLAY], cfg[CFG_CURSOR], cfg[CFG_BLINK]};
			2'd2: init_byte = 8'b0000_0001;     // clear display
			default: init_byte = {6'b000001, cfg[CFG_INC], cfg[CFG_SHIFT]};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= powerup;
			pre_cnt <= '0;
			us_cnt <= '0;
			step <= '0;
		end else begin
			if (state == idle) begin
				pre_cnt <= '0;
				us_cnt <= '0;
				if (start)
					state <= write;
			end else if (phase_done) begin
				pre_cnt <= '0;
				us_cnt <= '0;
				case (state)
					powerup: state <= init;
					init: begin
						step <= step + 2'd1;    // wraps back to 0 after entry mode
						if (step == 2'd3)
							state <= idle;
					end
					write: state <= idle;
					default: state <= idle;
				endcase
			end else begin
				if (us_tick) begin
					pre_cnt <= '0;
					us_cnt <= us_cnt + 1'b1;
				end else begin
					pre_cnt <= pre_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && start)
			word_q <= word;                     // held for the whole write phase
	end

	always_comb begin
		e = 1'b0;
		data = '0;
		rs = 1'b0;
		rw = 1'b0;
		case (state)
			init: begin
				e = (us_cnt < T_E_HIGH_US);
				data = init_byte;               // held through the wait as well
			end
			write: begin
				e = (us_cnt >= T_E_SETUP_US) && (us_cnt < T_E_END_US);
				data = word_q[7:0];
				rs = word_q[WORD_RS];
				rw = word_q[WORD_RW];
			end
			default: begin
				e = 1'b0;
			end
		endcase
	end

	assign busy = (state != idle);
	assign active = (state == init) || (state == write);

endmodule

//--- source/lcd_pkg.sv
package lcd_pkg;

	localparam int CLK_PER_US = 4;          // scaled down for short simulation
	localparam int NUM_PANELS = 2;          // controller chips on the shared bus

	// display intervals in microseconds
	localparam int T_POWERUP_US = 500;
	localparam int T_INIT_STEP_US = 50;     // wait after function set and display control
	localparam int T_CLEAR_US = 200;        // wait after clear
	localparam int T_ENTRY_US = 100;        // wait after entry mode
	localparam int T_WRITE_US = 50;         // full single-write phase
	localparam int T_E_HIGH_US = 10;        // enable width during init
	localparam int T_E_SETUP_US = 1;        // write: e low before rising
	localparam int T_E_END_US = 14;         // write: e falls here

	localparam int QUEUE_DEPTH = 8;

	// bit positions in the configuration word
	localparam int CFG_LINES = 6;
	localparam int CFG_FONT = 5;
	localparam int CFG_DISPLAY = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK = 2;
	localparam int CFG_INC = 1;
	localparam int CFG_SHIFT = 0;

	// bit positions in a write word
	localparam int WORD_RS = 9;
	localparam int WORD_RW = 8;

	typedef logic [7:0] lcd_byte_t;         // command or data byte
	typedef logic [9:0] lcd_word_t;         // {rs, rw, byte}
	typedef logic [6:0] lcd_cfg_t;          // lines, font, on, cursor, blink, inc, shift
	typedef logic [$clog2(NUM_PANELS)-1:0] panel_idx_t;

	typedef enum logic [1:0] {
		powerup,
		init,
		idle,
		write
	} panel_state_t;

endpackage
